/* hw/game_pkg.sv */
// ==============================
// Dodge game shared definitions
// Widths, screens, MAX7219 words and FSM states
// ==============================

package game_pkg;

	// Matrix geometry
	typedef logic [7:0] row_t;
	typedef logic [2:0] col_t;
	typedef logic [2:0] row_addr_t;

	// MAX7219 word: zero nibble, register address, data byte
	typedef logic [15:0] max_word_t;

	typedef enum logic [1:0] {
		st_start,
		st_go,
		st_play,
		st_lost
	} game_state_t;

	typedef enum logic [1:0] {
		st_init,
		st_read,
		st_shift,
		st_gap
	} drv_state_t;

	// ==============================
	// Fixed screens, row 0 at the bottom
	// ==============================
	localparam row_t screen_start [8] = '{
		8'b00000000, 8'b01100110, 8'b00100010, 8'b00100010,
		8'b01000100, 8'b01000100, 8'b01100110, 8'b00000000
	};

	localparam row_t screen_go [8] = '{
		8'b00000000, 8'b01100110, 8'b10011001, 8'b10111001,
		8'b10001001, 8'b10001001, 8'b01100110, 8'b00000000
	};

	// Cross
	localparam row_t screen_lost [8] = '{
		8'b10000001, 8'b01000010, 8'b00100100, 8'b00011000,
		8'b00011000, 8'b00100100, 8'b01000010, 8'b10000001
	};

	// ==============================
	// MAX7219 setup
	// ==============================
	// Decode off, scan all digits, intensity 10, wake up, test off
	localparam max_word_t init_words [5] = '{
		16'h0900, 16'h0B07, 16'h0A0A, 16'h0C01, 16'h0F00
	};

	// Digit 1 register
	localparam logic [3:0] digit_base = 4'd1;

	// Timing
	localparam int sclk_half = 2;
	// About 0.25 s at 50 MHz
	localparam int step_cycles_default = 12_500_000;
	// About 10 ms at 50 MHz
	localparam int debounce_cycles_default = 500_000;

	// Game
	localparam col_t start_col = 3'd3;
	localparam int go_steps = 4;

endpackage

/* hw/button_debounce.sv */
// ==============================
// Button debouncer
// Syncs an active-low button, one pulse per stable press
// ==============================
`timescale 1ns/10ps

module button_debounce import game_pkg::*; #(
	parameter int stable_cycles = debounce_cycles_default
) (
	input  logic clock_50,
	input  logic rst_n,
	input  logic btn_n,
	output logic press
);

	localparam int cnt_w = $clog2(stable_cycles + 1);

	logic sync1;
	logic sync2;
	logic [cnt_w-1:0] cnt;

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			sync1 <= 1'b1;
			sync2 <= 1'b1;
			// Start saturated so nothing fires after reset
			cnt <= cnt_w'(stable_cycles);
			press <= 1'b0;
		end else begin
			sync1 <= btn_n;
			sync2 <= sync1;
			// Restart on any level change
			if (sync1 != sync2)
				cnt <= '0;
			else if (cnt != cnt_w'(stable_cycles))
				cnt <= cnt + 1'b1;
			// Fires once, only for the pressed level
			press <= !sync2 && (sync1 == sync2) && (cnt == cnt_w'(stable_cycles - 1));
		end
	end

endmodule

/* hw/game_engine.sv */
// ==============================
// Dodge game engine
// Game FSM, player, falling obstacles, frame writes
// ==============================
`timescale 1ns/10ps

module game_engine import game_pkg::*; #(
	parameter int step_cycles = step_cycles_default
) (
	input  logic      clock_50,
	input  logic      rst_n,
	input  logic      start_press,
	input  logic      left_press,
	input  logic      right_press,
	output logic      fb_we,
	output row_addr_t fb_waddr,
	output row_t      fb_wdata
);

	localparam int step_w = $clog2(step_cycles + 1);

	game_state_t state;
	logic [step_w-1:0] step_cnt;
	logic step_tick;
	logic start_go;
	logic [2:0] go_cnt;
	logic step_odd;
	col_t player_col;
	row_t obst [1:7];
	logic [7:0] lfsr;
	logic redraw_req;
	logic wr_busy;
	row_addr_t wr_row;

	assign step_tick = (step_cnt == step_w'(step_cycles - 1));
	assign start_go = start_press && (state == st_start || state == st_lost);

	// Step timer, restarted when a game begins
	always_ff @(posedge clock_50) begin
		if (!rst_n)
			step_cnt <= '0;
		else if (start_go || step_tick)
			step_cnt <= '0;
		else
			step_cnt <= step_cnt + 1'b1;
	end

	// Free running LFSR, x^8 + x^6 + x^5 + x^4 + 1
	always_ff @(posedge clock_50) begin
		if (!rst_n)
			lfsr <= 8'h01;
		else
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	// ==============================
	// Game FSM
	// ==============================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= st_start;
			go_cnt <= '0;
			step_odd <= 1'b0;
			player_col <= start_col;
			for (int i = 1; i <= 7; i++)
				obst[i] <= '0;
		end else if (start_go) begin
			state <= st_go;
			go_cnt <= '0;
			step_odd <= 1'b0;
			player_col <= start_col;
			for (int i = 1; i <= 7; i++)
				obst[i] <= '0;
		end else begin
			// Left is toward bit 7
			if (state == st_go || state == st_play) begin
				if (left_press && player_col != 3'd7)
					player_col <= player_col + 1'b1;
				else if (right_press && player_col != 3'd0)
					player_col <= player_col - 1'b1;
			end
			if (step_tick) begin
				case (state)
					st_go: begin
						if (go_cnt == 3'(go_steps - 1))
							state <= st_play;
						else
							go_cnt <= go_cnt + 1'b1;
					end
					st_play: begin
						if (obst[1][player_col]) begin
							state <= st_lost;
						end else begin
							for (int i = 1; i <= 6; i++)
								obst[i] <= obst[i + 1];
							// New obstacle every other step
							if (step_odd)
								obst[7] <= '0;
							else
								obst[7] <= row_t'(8'd1 << lfsr[2:0]);
							step_odd <= !step_odd;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// ==============================
	// Frame rewrite, rows 0 to 7
	// ==============================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			// Draw the start screen once out of reset
			redraw_req <= 1'b1;
			wr_busy <= 1'b0;
			wr_row <= '0;
		end else begin
			redraw_req <= start_go || step_tick;
			if (redraw_req) begin
				wr_busy <= 1'b1;
				wr_row <= '0;
			end else if (wr_busy) begin
				wr_row <= wr_row + 1'b1;
				if (wr_row == 3'd7)
					wr_busy <= 1'b0;
			end
		end
	end

	assign fb_we = wr_busy;
	assign fb_waddr = wr_row;

	always_comb begin
		case (state)
			st_start: fb_wdata = screen_start[wr_row];
			st_go:    fb_wdata = screen_go[wr_row];
			st_lost:  fb_wdata = screen_lost[wr_row];
			default: begin
				// Player alone on the bottom row
				if (wr_row == 3'd0)
					fb_wdata = row_t'(8'd1 << player_col);
				else
					fb_wdata = obst[wr_row];
			end
		endcase
	end

endmodule

/* hw/frame_buffer.sv */
// ==============================
// Frame buffer
// Eight rows, write strobe in, Wishbone read out
// ==============================
`timescale 1ns/10ps

module frame_buffer import game_pkg::*; (
	input  logic      clock_50,
	input  logic      rst_n,
	input  logic      we,
	input  row_addr_t waddr,
	input  row_t      wdata,
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  row_addr_t wb_adr,
	output logic      wb_ack,
	output row_t      wb_dat_o
);

	row_t rows [8];

	// Write port
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				rows[i] <= '0;
		end else if (we) begin
			rows[waddr] <= wdata;
		end
	end

	// One wait state, ack drops the cycle after
	always_ff @(posedge clock_50) begin
		if (!rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_cyc && wb_stb && !wb_ack;
	end

	always_ff @(posedge clock_50) begin
		if (wb_cyc && wb_stb)
			wb_dat_o <= rows[wb_adr];
	end

endmodule

/* hw/max7219_driver.sv */
// ==============================
// MAX7219 serial driver
// Init words, then row scan read over Wishbone
// ==============================
`timescale 1ns/10ps

module max7219_driver import game_pkg::*; (
	input  logic      clock_50,
	input  logic      rst_n,
	output logic      wb_cyc,
	output logic      wb_stb,
	output row_addr_t wb_adr,
	input  logic      wb_ack,
	input  row_t      wb_dat_o,
	output logic      max_din,
	output logic      max_ncs,
	output logic      max_sclk
);

	localparam int phase_w = $clog2(sclk_half + 1);

	drv_state_t state;
	logic [2:0] init_idx;
	logic init_done;
	row_addr_t row_idx;
	max_word_t shreg;
	max_word_t next_word;
	logic [3:0] bit_cnt;
	logic [phase_w-1:0] phase_cnt;
	logic phase_end;
	logic load_word;

	assign wb_stb = wb_cyc;
	assign wb_adr = row_idx;
	assign phase_end = (phase_cnt == phase_w'(sclk_half - 1));
	assign load_word = (state == st_init) || (state == st_read && wb_ack);

	// Row n goes to digit n+1
	always_comb begin
		if (init_done)
			next_word = {4'h0, digit_base + 4'(row_idx), wb_dat_o};
		else
			next_word = init_words[init_idx];
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= st_init;
			init_idx <= '0;
			init_done <= 1'b0;
			row_idx <= '0;
			bit_cnt <= '0;
			phase_cnt <= '0;
			wb_cyc <= 1'b0;
			max_ncs <= 1'b1;
			max_sclk <= 1'b0;
			max_din <= 1'b0;
		end else if (load_word) begin
			// Start of word, MSB on the pin while sclk is low
			wb_cyc <= 1'b0;
			shreg <= next_word;
			max_din <= next_word[15];
			max_ncs <= 1'b0;
			bit_cnt <= '0;
			phase_cnt <= '0;
			state <= st_shift;
		end else begin
			case (state)
				st_read: wb_cyc <= 1'b1;
				st_shift: begin
					if (!phase_end) begin
						phase_cnt <= phase_cnt + 1'b1;
					end else begin
						phase_cnt <= '0;
						if (!max_sclk) begin
							max_sclk <= 1'b1;
						end else begin
							max_sclk <= 1'b0;
							// Latch after the 16th falling edge
							if (bit_cnt == 4'd15) begin
								max_ncs <= 1'b1;
								state <= st_gap;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
								shreg <= {shreg[14:0], 1'b0};
								max_din <= shreg[14];
							end
						end
					end
				end
				st_gap: begin
					// ncs high for one phase
					if (!phase_end) begin
						phase_cnt <= phase_cnt + 1'b1;
					end else begin
						phase_cnt <= '0;
						state <= st_read;
						if (init_done) begin
							row_idx <= row_idx + 1'b1;
						end else if (init_idx == 3'd4) begin
							init_done <= 1'b1;
						end else begin
							init_idx <= init_idx + 1'b1;
							state <= st_init;
						end
					end
				end
				default: ;
			endcase
		end
	end

endmodule

/* hw/dodge_top.sv */
// ==============================
// Dodge game top level
// Debouncers, engine, frame buffer, MAX7219 driver
// ==============================
`timescale 1ns/10ps

module dodge_top import game_pkg::*; #(
	parameter int step_cycles = step_cycles_default,
	parameter int debounce_cycles = debounce_cycles_default
) (
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_btn_n,
	input  logic left_btn_n,
	input  logic right_btn_n,
	output logic max_din,
	output logic max_ncs,
	output logic max_sclk
);

	logic start_press;
	logic left_press;
	logic right_press;
	logic fb_we;
	row_addr_t fb_waddr;
	row_t fb_wdata;
	logic wb_cyc;
	logic wb_stb;
	row_addr_t wb_adr;
	logic wb_ack;
	row_t wb_dat_o;

	// Buttons
	button_debounce #(.stable_cycles(debounce_cycles)) u_start_db (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.btn_n(start_btn_n),
		.press(start_press)
	);

	button_debounce #(.stable_cycles(debounce_cycles)) u_left_db (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.btn_n(left_btn_n),
		.press(left_press)
	);

	button_debounce #(.stable_cycles(debounce_cycles)) u_right_db (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.btn_n(right_btn_n),
		.press(right_press)
	);

	game_engine #(.step_cycles(step_cycles)) u_engine (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.start_press(start_press),
		.left_press(left_press),
		.right_press(right_press),
		.fb_we(fb_we),
		.fb_waddr(fb_waddr),
		.fb_wdata(fb_wdata)
	);

	frame_buffer u_fb (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.we(fb_we),
		.waddr(fb_waddr),
		.wdata(fb_wdata),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_ack(wb_ack),
		.wb_dat_o(wb_dat_o)
	);

	// Matrix driver
	max7219_driver u_drv (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_ack(wb_ack),
		.wb_dat_o(wb_dat_o),
		.max_din(max_din),
		.max_ncs(max_ncs),
		.max_sclk(max_sclk)
	);

endmodule

/* bench/max7219_monitor.sv */
// ==============================
// MAX7219 serial monitor
// Rebuilds words and scans, checks the serial timing
// ==============================
`timescale 1ns/10ps

module max7219_monitor import game_pkg::*; (
	input  logic clock_50,
	input  logic rst_n,
	input  logic max_din,
	input  logic max_ncs,
	input  logic max_sclk,
	output row_t scan_rows [8],
	output int   scan_cnt,
	output int   errors
);

	max_word_t shift_in;
	logic ncs_q = 1'b1;
	logic sclk_q = 1'b0;
	logic din_q = 1'b0;
	logic [2:0] init_idx = '0;
	logic [7:0] digit_seen = '0;
	logic [3:0] addr;
	row_addr_t ridx;
	int edge_cnt = 0;
	row_t rows_tmp [8];

	// Pins move on the rising system edge, so sample on the falling one
	always @(negedge clock_50) begin
		if (!rst_n) begin
			assert (max_ncs === 1'b1 && max_sclk === 1'b0) else begin
				errors++;
				$display("FAIL %0t: ncs=%b sclk=%b during reset", $time, max_ncs, max_sclk);
			end
			init_idx = '0;
			digit_seen = '0;
		end else begin
			// Word start
			if (ncs_q && !max_ncs) begin
				edge_cnt = 0;
				shift_in = '0;
			end
			if (!max_ncs && max_sclk && !sclk_q) begin
				shift_in = {shift_in[14:0], max_din};
				edge_cnt++;
			end
			assert (!(max_sclk && sclk_q && max_din !== din_q)) else begin
				errors++;
				$display("FAIL %0t: din changed while sclk was high", $time);
			end
			// ==============================
			// Word end on ncs rising
			// ==============================
			if (!ncs_q && max_ncs) begin
				assert (edge_cnt == 16) else begin
					errors++;
					$display("FAIL %0t: word had %0d sclk rising edges, expected 16",
						$time, edge_cnt);
				end
				if (init_idx != 3'd5) begin
					assert (shift_in == init_words[init_idx]) else begin
						errors++;
						$display("FAIL %0t: init word %0d is %h, expected %h",
							$time, init_idx, shift_in, init_words[init_idx]);
					end
					init_idx = init_idx + 3'd1;
				end else begin
					addr = shift_in[11:8];
					assert (shift_in[15:12] == 4'h0 && addr >= 4'd1 && addr <= 4'd8) else begin
						errors++;
						$display("FAIL %0t: word %h is not a digit write", $time, shift_in);
					end
					ridx = row_addr_t'(addr - 4'd1);
					rows_tmp[ridx] = shift_in[7:0];
					digit_seen[ridx] = 1'b1;
					// Digit 8 closes a scan
					if (addr == 4'd8) begin
						if (digit_seen == 8'hFF) begin
							scan_rows = rows_tmp;
							scan_cnt++;
						end
						digit_seen = '0;
					end
				end
			end
		end
		ncs_q = max_ncs;
		sclk_q = max_sclk;
		din_q = max_din;
	end

endmodule

/* bench/tb_dodge.sv */
// ==============================
// Dodge game testbench
// Button stimulus, scan checks, watchdog and verdict
// ==============================
`timescale 1ns/10ps

module tb_dodge import game_pkg::*; ();

	localparam int clk_period = 100;
	localparam int tb_step_cycles = 2000;
	localparam int tb_debounce_cycles = 4;
	// Game steps the whole run may need
	localparam int test_steps = 150;
	localparam int watchdog_ns = test_steps * tb_step_cycles * clk_period * 3 / 2;
	localparam int btn_start = 0;
	localparam int btn_left = 1;
	localparam int btn_right = 2;

	logic clock_50;
	logic rst_n;
	logic start_btn_n;
	logic left_btn_n;
	logic right_btn_n;
	logic max_din;
	logic max_ncs;
	logic max_sclk;
	row_t scan_rows [8];
	row_t last_play [8];
	int scan_cnt;
	int mon_errors;
	int errors;
	int unsigned seed;
	bit seen;
	bit have_play;

	dodge_top #(
		.step_cycles(tb_step_cycles),
		.debounce_cycles(tb_debounce_cycles)
	) UUT (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.start_btn_n(start_btn_n),
		.left_btn_n(left_btn_n),
		.right_btn_n(right_btn_n),
		.max_din(max_din),
		.max_ncs(max_ncs),
		.max_sclk(max_sclk)
	);

	max7219_monitor u_mon (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.max_din(max_din),
		.max_ncs(max_ncs),
		.max_sclk(max_sclk),
		.scan_rows(scan_rows),
		.scan_cnt(scan_cnt),
		.errors(mon_errors)
	);

	initial begin
		clock_50 = 1'b0;
		forever #(clk_period / 2) clock_50 = ~clock_50;
	end

	task automatic check(input bit ok, input string msg);
		assert (ok) else begin
			errors++;
			$display("FAIL %0t: %s", $time, msg);
		end
	endtask

	// Held for 10 cycles, then a random idle gap
	task automatic press_button(input int which);
		int unsigned gap;
		@(posedge clock_50);
		#10;
		case (which)
			btn_start: start_btn_n = 1'b0;
			btn_left:  left_btn_n = 1'b0;
			default:   right_btn_n = 1'b0;
		endcase
		repeat (10) @(posedge clock_50);
		#10;
		start_btn_n = 1'b1;
		left_btn_n = 1'b1;
		right_btn_n = 1'b1;
		gap = $urandom_range(60, 20);
		repeat (gap) @(posedge clock_50);
	endtask

	task automatic next_scan();
		int n;
		n = scan_cnt;
		wait (scan_cnt != n);
		#1;
	endtask

	function automatic row_t player_row(input int col);
		return row_t'(8'd1 << col);
	endfunction

	function automatic bit scan_is(input row_t exp [8]);
		bit same;
		same = 1'b1;
		for (int i = 0; i < 8; i++)
			if (scan_rows[i] != exp[i])
				same = 1'b0;
		return same;
	endfunction

	// Obstacle rows hold one bit at most
	function automatic bit rows_sparse();
		bit ok;
		ok = 1'b1;
		for (int i = 1; i < 8; i++)
			if ($countones(scan_rows[i]) > 1)
				ok = 1'b0;
		return ok;
	endfunction

	task automatic wait_screen(input row_t exp [8], input int max_scans, output bit found);
		found = 1'b0;
		for (int s = 0; s < max_scans && !found; s++) begin
			next_scan();
			found = scan_is(exp);
		end
	endtask

	task automatic wait_player(input int col, input int max_scans, output bit found);
		found = 1'b0;
		for (int s = 0; s < max_scans && !found; s++) begin
			next_scan();
			found = (scan_rows[0] == player_row(col));
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		seed = $urandom(59);
		rst_n = 1'b0;
		start_btn_n = 1'b1;
		left_btn_n = 1'b1;
		right_btn_n = 1'b1;
		repeat (4) @(posedge clock_50);
		#10;
		rst_n = 1'b1;

		// Start screen before any press
		for (int i = 0; i < 3; i++) begin
			next_scan();
			check(scan_is(screen_start), "scan differs from the start screen");
		end

		press_button(btn_start);
		wait_screen(screen_go, 10, seen);
		check(seen, "go screen not shown after start press");
		wait_player(start_col, 40, seen);
		check(seen, "player never appeared at the start column");
		check(rows_sparse(), "obstacle row with more than one bit at play start");

		// Movement and saturation at column 0
		press_button(btn_left);
		press_button(btn_left);
		wait_player(start_col + 2, 10, seen);
		check(seen, "digit 1 never showed the player two columns left of the start");
		repeat (10) press_button(btn_right);
		wait_player(0, 10, seen);
		check(seen, "digit 1 never showed column 0 after ten right presses");
		// Long enough to span a game step
		for (int i = 0; i < 5; i++) begin
			next_scan();
			check(scan_rows[0] == player_row(0),
				$sformatf("digit 1 is %b after ten right presses, expected %b",
					scan_rows[0], player_row(0)));
		end

		// Collision, remembering the last clean play scan
		seen = 1'b0;
		have_play = 1'b0;
		for (int s = 0; s < 400 && !seen; s++) begin
			next_scan();
			if (scan_is(screen_lost)) begin
				seen = 1'b1;
			end else if (scan_rows[0] == player_row(0) && rows_sparse()) begin
				last_play = scan_rows;
				have_play = 1'b1;
			end
		end
		check(seen, "lost screen never appeared");
		check(have_play && (last_play[1] & player_row(0)) != '0,
			"last play scan has no obstacle at the player column in row 1");

		press_button(btn_start);
		wait_screen(screen_go, 10, seen);
		check(seen, "go screen not shown after restart");

		$display("Errors: %0d bench, %0d monitor", errors, mon_errors);
		if (errors == 0 && mon_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* flist.f */
hw/game_pkg.sv
hw/button_debounce.sv
hw/game_engine.sv
hw/frame_buffer.sv
hw/max7219_driver.sv
hw/dodge_top.sv
bench/max7219_monitor.sv
bench/tb_dodge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dodge game testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_dodge -f flist.f -o sim_dodge
./obj_dir/sim_dodge > sim.log 2>&1
cat sim.log

if grep -qF "** FAIL **" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
